/* isa_pkg.sv */
// instruction set package with field layout, kept opcodes and field decoders
package isa_pkg;

	typedef enum logic [2:0] {
		OP_LW,
		OP_RW,
		OP_UJ,
		OP_SHC,
		OP_LWRS,
		OP_HLT,
		OP_ILL
	} op_t;

	// opcode codes in bits 15..10
	localparam logic [5:0] OPC_LW   = 6'h10;
	localparam logic [5:0] OPC_RW   = 6'h11;
	localparam logic [5:0] OPC_UJ   = 6'h18;
	localparam logic [5:0] OPC_SHC  = 6'h1c;
	localparam logic [5:0] OPC_LWRS = 6'h14;
	localparam logic [5:0] OPC_HLT  = 6'h1f;

	// field positions, bit 9 unused here
	localparam int OP_HI  = 15;
	localparam int OP_LO  = 10;
	localparam int A_HI   = 8;
	localparam int A_LO   = 6;
	localparam int B_HI   = 5;
	localparam int B_LO   = 3;
	localparam int C_HI   = 2;
	localparam int C_LO   = 0;
	localparam int SHC_HI = 3;
	localparam int SHC_LO = 0;

	function automatic op_t ir_op(input logic [15:0] ir);
		case (ir[OP_HI:OP_LO])
			OPC_LW:   return OP_LW;
			OPC_RW:   return OP_RW;
			OPC_UJ:   return OP_UJ;
			OPC_SHC:  return OP_SHC;
			OPC_LWRS: return OP_LWRS;
			OPC_HLT:  return OP_HLT;
			default:  return OP_ILL;
		endcase
	endfunction

	function automatic logic [2:0] ir_a(input logic [15:0] ir);
		return ir[A_HI:A_LO];
	endfunction

	function automatic logic [2:0] ir_b(input logic [15:0] ir);
		return ir[B_HI:B_LO];
	endfunction

	function automatic logic [2:0] ir_c(input logic [15:0] ir);
		return ir[C_HI:C_LO];
	endfunction

	// shift count overlaps the low bit of b
	function automatic logic [3:0] ir_shc(input logic [15:0] ir);
		return ir[SHC_HI:SHC_LO];
	endfunction

	// argument word follows when c is zero
	function automatic logic is_two_word(input op_t op, input logic [2:0] c);
		return (c == 3'd0) && !(op inside {OP_SHC, OP_HLT});
	endfunction

	function automatic logic is_bmod(input op_t op, input logic [2:0] b);
		return (b != 3'd0) && !(op inside {OP_SHC, OP_HLT});
	endfunction

endpackage

/* mcu_pkg.sv */
// control unit package with sequencer states, counter widths and strobe bundle
package mcu_pkg;

	// state code is what leaves the top level
	typedef enum logic [3:0] {
		ST_IDLE   = 4'd0,
		ST_FETCH  = 4'd1,
		ST_DECODE = 4'd2,
		ST_ARG    = 4'd3,
		ST_BMOD   = 4'd4,
		ST_EXEC   = 4'd5,
		ST_KC     = 4'd6,
		ST_PC     = 4'd7,
		ST_IRQ    = 4'd8
	} state_t;

	// group counter and step counter widths
	localparam int LG_W = 3;
	localparam int LK_W = 4;

	// one bundle of microoperation strobes
	typedef struct packed {
		logic       mem_rd;
		logic       mem_wr;
		logic       w_ir;
		logic       w_ac;
		logic       w_ar;
		logic       w_ic;
		logic       w_r;
		logic       shift_step;
		logic       irq_ack;
		logic [2:0] reg_sel;
	} uop_t;

endpackage

/* mcu_if.sv */
// interfaces between panel, sequencer, counters and microoperation decoder

interface ctl_if;
	logic started;
	logic run;
	logic step_req;
	logic hlt_exec;
	logic irq_taken;
	logic step_done;

	modport panel (output started, run, step_req, input hlt_exec, irq_taken, step_done);
	modport seq (input started, run, step_req, output hlt_exec, irq_taken, step_done);
endinterface

interface cnt_if;
	import mcu_pkg::*;

	logic            load;
	logic [LG_W-1:0] lg_last;
	logic [LK_W-1:0] lk_init;
	logic            lg_mode;
	logic            lk_mode;
	logic            step;
	logic [LG_W-1:0] lg;
	logic            done;

	modport seq (output load, lg_last, lk_init, lg_mode, lk_mode, step, input lg, done);
	modport cnt (input load, lg_last, lk_init, lg_mode, lk_mode, step, output lg, done);
endinterface

interface seq_if;
	import mcu_pkg::*;
	import isa_pkg::*;

	state_t          state;
	op_t             op;
	logic [2:0]      a;
	logic [2:0]      b;
	logic [2:0]      c;
	logic            first;
	logic            mem_ok_seen;
	logic [LG_W-1:0] lg;

	modport seq (output state, op, a, b, c, first, mem_ok_seen, lg);
	modport uop (input state, op, a, b, c, first, mem_ok_seen, lg);
endinterface

/* mcu_panel.sv */
// control panel flip-flops START, WAIT and CYCLE giving run and step requests
module mcu_panel (
	input  logic __clk,
	input  logic rst_n,
	input  logic start,
	input  logic stop,
	input  logic cycle,
	ctl_if.panel ctl,
	output logic halted
);

	logic start_q;
	logic wait_q;
	logic cycle_q;

	// START, cleared by stop
	always_ff @(posedge __clk) begin
		if (!rst_n || stop) begin
			start_q <= 1'b0;
		end else if (start) begin
			start_q <= 1'b1;
		end
	end

	// WAIT, set by an executed HLT
	always_ff @(posedge __clk) begin
		if (!rst_n || stop || ctl.irq_taken) begin
			wait_q <= 1'b0;
		end else if (ctl.hlt_exec) begin
			wait_q <= 1'b1;
		end
	end

	// CYCLE only arms while stopped
	always_ff @(posedge __clk) begin
		if (!rst_n || ctl.irq_taken || ctl.step_done) begin
			cycle_q <= 1'b0;
		end else if (cycle && !start_q) begin
			cycle_q <= 1'b1;
		end
	end

	assign ctl.started  = start_q;
	assign ctl.run      = start_q && !wait_q;
	assign ctl.step_req = cycle_q;
	assign halted       = wait_q;

endmodule

/* mcu_sequencer.sv */
// instruction sequencer with instruction register, cycle phases and interrupt entry
module mcu_sequencer #(
	parameter int KC_TICKS = 2,
	parameter int PC_TICKS = 1
) (
	input  logic        __clk,
	input  logic        rst_n,
	input  logic        irq,
	input  logic        mem_ok,
	input  logic [15:0] rdt,
	ctl_if.seq          ctl,
	cnt_if.seq          cnt,
	seq_if.seq          seq
);
	import isa_pkg::*;
	import mcu_pkg::*;

	// phase counter covers KC, PC and the two IRQ cycles
	localparam int TICK_MAX = (KC_TICKS > PC_TICKS) ? KC_TICKS : PC_TICKS;
	localparam int PH_MAX   = (TICK_MAX > 2) ? TICK_MAX : 2;
	localparam int PH_W     = $clog2(PH_MAX);

	localparam logic [PH_W-1:0] KC_LAST  = PH_W'(KC_TICKS - 1);
	localparam logic [PH_W-1:0] PC_LAST  = PH_W'(PC_TICKS - 1);
	localparam logic [PH_W-1:0] IRQ_LAST = PH_W'(1);

	state_t          state;
	state_t          state_nx;
	logic            first;
	logic [15:0]     ir;
	logic [PH_W-1:0] ph;
	logic            ph_last;
	op_t             op;
	logic [2:0]      f_a;
	logic [2:0]      f_b;
	logic [2:0]      f_c;

	assign op  = ir_op(ir);
	assign f_a = ir_a(ir);
	assign f_b = ir_b(ir);
	assign f_c = ir_c(ir);

	always_comb begin
		case (state)
			ST_KC:   ph_last = (ph == KC_LAST);
			ST_IRQ:  ph_last = (ph == IRQ_LAST);
			ST_PC:   ph_last = (ph == PC_LAST);
			default: ph_last = 1'b0;
		endcase
	end

	always_comb begin
		state_nx = state;
		case (state)
			ST_IDLE: begin
				if (ctl.run || ctl.step_req) begin
					state_nx = ST_FETCH;
				end else if (ctl.started && irq) begin
					state_nx = ST_IRQ;
				end
			end
			ST_FETCH: begin
				if (mem_ok) begin
					state_nx = ST_DECODE;
				end
			end
			ST_DECODE: begin
				if (is_two_word(op, f_c)) begin
					state_nx = ST_ARG;
				end else if (is_bmod(op, f_b)) begin
					state_nx = ST_BMOD;
				end else begin
					state_nx = ST_EXEC;
				end
			end
			ST_ARG: begin
				if (mem_ok) begin
					state_nx = is_bmod(op, f_b) ? ST_BMOD : ST_EXEC;
				end
			end
			ST_BMOD: state_nx = ST_EXEC;
			ST_EXEC: begin
				if (cnt.done) begin
					state_nx = ST_KC;
				end
			end
			ST_KC: begin
				// interrupt is taken only at the end of a cycle
				if (ph_last) begin
					state_nx = (irq && (ctl.started || ctl.step_req)) ? ST_IRQ : ST_PC;
				end
			end
			ST_IRQ: begin
				if (ph_last) begin
					state_nx = ST_PC;
				end
			end
			ST_PC: begin
				if (ph_last) begin
					state_nx = ctl.run ? ST_FETCH : ST_IDLE;
				end
			end
			default: state_nx = ST_IDLE;
		endcase
	end

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
			first <= 1'b1;
			ph    <= '0;
		end else begin
			state <= state_nx;
			first <= (state_nx != state);
			if (state_nx != state) begin
				ph <= '0;
			end else if (state inside {ST_KC, ST_IRQ, ST_PC}) begin
				ph <= ph + 1'b1;
			end
		end
	end

	// instruction word latched when the fetch completes
	always_ff @(posedge __clk) begin
		if (state == ST_FETCH && mem_ok) begin
			ir <= rdt;
		end
	end

	assign ctl.hlt_exec  = (state == ST_EXEC) && (op == OP_HLT);
	assign ctl.irq_taken = (state == ST_IRQ) && first;
	assign ctl.step_done = (state == ST_PC) && ph_last;

	assign cnt.load    = (state == ST_DECODE);
	assign cnt.lg_last = f_a;
	assign cnt.lk_init = ir_shc(ir);
	assign cnt.lg_mode = (op == OP_LWRS);
	assign cnt.lk_mode = (op == OP_SHC);
	assign cnt.step    = (state == ST_EXEC);

	assign seq.state       = state;
	assign seq.op          = op;
	assign seq.a           = f_a;
	assign seq.b           = f_b;
	assign seq.c           = f_c;
	assign seq.first       = first;
	assign seq.mem_ok_seen = mem_ok && (state == ST_FETCH || state == ST_ARG);
	assign seq.lg          = cnt.lg;

endmodule

/* mcu_counters.sv */
// group counter lg and step counter lk timing the execute phase
module mcu_counters (
	input  logic __clk,
	input  logic rst_n,
	cnt_if.cnt   cnt
);
	import mcu_pkg::*;

	logic [LG_W-1:0] lg;
	logic [LG_W-1:0] lg_last;
	logic [LK_W-1:0] lk;
	logic            lg_mode;
	logic            lk_mode;
	logic            done;

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			lg      <= '0;
			lg_last <= '0;
			lk      <= '0;
			lg_mode <= 1'b0;
			lk_mode <= 1'b0;
		end else if (cnt.load) begin
			lg      <= '0;
			lg_last <= cnt.lg_last;
			lk      <= cnt.lk_init;
			lg_mode <= cnt.lg_mode;
			lk_mode <= cnt.lk_mode;
		end else if (cnt.step && !done) begin
			if (lg_mode) begin
				lg <= lg + 1'b1;
			end
			if (lk_mode) begin
				lk <= lk - 1'b1;
			end
		end
	end

	// single-cycle opcodes finish in their first execute cycle
	always_comb begin
		if (lg_mode) begin
			done = (lg == lg_last);
		end else if (lk_mode) begin
			// zero count still takes one cycle
			done = (lk <= LK_W'(1));
		end else begin
			done = 1'b1;
		end
	end

	assign cnt.lg   = lg;
	assign cnt.done = done;

endmodule

/* mcu_microops.sv */
// registered decoder of sequencer state and opcode into microoperation strobes
module mcu_microops (
	input  logic        __clk,
	input  logic        rst_n,
	seq_if.uop          seq,
	output mcu_pkg::uop_t uop,
	output logic [3:0]  state_code
);
	import isa_pkg::*;
	import mcu_pkg::*;

	uop_t uop_nx;
	logic shc_nz;

	// shift count spans c and the low bit of b
	assign shc_nz = ({seq.b[0], seq.c} != 4'd0);

	always_comb begin
		uop_nx = '0;
		case (seq.state)
			ST_FETCH: uop_nx.mem_rd = seq.first;
			ST_ARG: begin
				uop_nx.mem_rd = seq.first;
				uop_nx.w_ac   = seq.mem_ok_seen;
			end
			ST_DECODE: begin
				uop_nx.w_ir    = 1'b1;
				uop_nx.reg_sel = seq.c;
			end
			ST_BMOD: begin
				uop_nx.w_ac    = 1'b1;
				uop_nx.reg_sel = seq.b;
			end
			ST_EXEC: begin
				case (seq.op)
					OP_LW: begin
						uop_nx.w_r     = 1'b1;
						uop_nx.reg_sel = seq.a;
					end
					OP_RW: begin
						uop_nx.w_ar    = 1'b1;
						uop_nx.mem_wr  = 1'b1;
						uop_nx.reg_sel = seq.a;
					end
					OP_UJ: uop_nx.w_ic = 1'b1;
					OP_SHC: begin
						uop_nx.shift_step = shc_nz;
						uop_nx.reg_sel    = seq.a;
					end
					OP_LWRS: begin
						uop_nx.w_r     = 1'b1;
						uop_nx.reg_sel = seq.lg;
					end
					default: uop_nx = '0;
				endcase
			end
			// acknowledge first, then load the vector into IC
			ST_IRQ: begin
				uop_nx.irq_ack = seq.first;
				uop_nx.w_ic    = !seq.first;
			end
			default: uop_nx = '0;
		endcase
	end

	always_ff @(posedge __clk) begin
		if (!rst_n) begin
			uop        <= '0;
			state_code <= ST_IDLE;
		end else begin
			uop        <= uop_nx;
			state_code <= seq.state;
		end
	end

endmodule

/* mcu_top.sv */
// microinstruction control unit top level with plain strobe ports
module mcu_top #(
	parameter int KC_TICKS = 2,
	parameter int PC_TICKS = 1
) (
	input  logic        __clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic        stop,
	input  logic        cycle,
	input  logic        irq,
	input  logic        mem_ok,
	input  logic [15:0] rdt,
	output logic        run,
	output logic        halted,
	output logic        mem_rd,
	output logic        mem_wr,
	output logic        w_ir,
	output logic        w_ac,
	output logic        w_ar,
	output logic        w_ic,
	output logic        w_r,
	output logic        shift_step,
	output logic        irq_ack,
	output logic [2:0]  reg_sel,
	output logic [3:0]  state_code
);
	import mcu_pkg::*;

	uop_t uop;

	ctl_if ctl0 ();
	cnt_if cnt0 ();
	seq_if seq0 ();

	mcu_panel panel0 (
		.__clk  (__clk),
		.rst_n  (rst_n),
		.start  (start),
		.stop   (stop),
		.cycle  (cycle),
		.ctl    (ctl0.panel),
		.halted (halted)
	);

	mcu_sequencer #(
		.KC_TICKS (KC_TICKS),
		.PC_TICKS (PC_TICKS)
	) seq_u0 (
		.__clk  (__clk),
		.rst_n  (rst_n),
		.irq    (irq),
		.mem_ok (mem_ok),
		.rdt    (rdt),
		.ctl    (ctl0.seq),
		.cnt    (cnt0.seq),
		.seq    (seq0.seq)
	);

	mcu_counters cnt_u0 (
		.__clk (__clk),
		.rst_n (rst_n),
		.cnt   (cnt0.cnt)
	);

	mcu_microops uop_u0 (
		.__clk      (__clk),
		.rst_n      (rst_n),
		.seq        (seq0.uop),
		.uop        (uop),
		.state_code (state_code)
	);

	assign run        = ctl0.run;
	assign mem_rd     = uop.mem_rd;
	assign mem_wr     = uop.mem_wr;
	assign w_ir       = uop.w_ir;
	assign w_ac       = uop.w_ac;
	assign w_ar       = uop.w_ar;
	assign w_ic       = uop.w_ic;
	assign w_r        = uop.w_r;
	assign shift_step = uop.shift_step;
	assign irq_ack    = uop.irq_ack;
	assign reg_sel    = uop.reg_sel;

endmodule

/* mcu_asserts.sv */
// concurrent checks on the strobes leaving the control unit top level
module mcu_asserts (
	input logic       __clk,
	input logic       rst_n,
	input logic       mem_rd,
	input logic       mem_wr,
	input logic       w_ir,
	input logic       w_ac,
	input logic       w_ar,
	input logic       w_ic,
	input logic       w_r,
	input logic       shift_step,
	input logic       irq_ack,
	input logic [2:0] reg_sel
);

	logic [11:0] strobes;

	assign strobes = {mem_rd, mem_wr, w_ir, w_ac, w_ar, w_ic, w_r, shift_step, irq_ack, reg_sel};

	// read and write strobes exclude each other
	a_rd_wr: assert property (@(posedge __clk) disable iff (!rst_n) !(mem_rd && mem_wr))
		else $error("mem_rd and mem_wr high in the same cycle");

	// acknowledge is a single-cycle pulse
	a_ack: assert property (@(posedge __clk) disable iff (!rst_n) irq_ack |=> !irq_ack)
		else $error("irq_ack high for two cycles in a row");

	// outputs are registered, so quiet from the second reset cycle on
	a_rst: assert property (@(posedge __clk) (!rst_n && $past(!rst_n)) |-> (strobes == '0))
		else $error("strobes active while reset is held");

endmodule

/* tb_mcu.sv */
// testbench for the control unit with memory model, random programs and cycle model
module tb_mcu;
	import isa_pkg::*;
	import mcu_pkg::*;

	parameter int KC_TICKS = 2;
	parameter int PC_TICKS = 1;
	localparam int LIMIT = 4000;

	logic clk = 1'b0;
	logic rst_n, start, stop, cycle, irq, mem_ok;
	logic [15:0] rdt;
	logic run, halted, mem_rd, mem_wr, w_ir, w_ac, w_ar, w_ic, w_r, shift_step, irq_ack;
	logic [2:0] reg_sel;
	logic [3:0] state_code;

	// model state
	state_t m_state;
	logic m_first, m_start, m_wait, m_cyc;
	logic [15:0] m_ir;
	int m_ph, m_e, m_kc_cnt;
	uop_t m_uop;
	state_t m_code;

	int errs, test_errs, tests_run, tests_failed, prog_mode, mem_wait, ir_cnt, sh_cnt, wr_cnt;
	logic checking, irq_rand, have_w, timed_out;
	logic [15:0] cur_w;
	string cur_test;

	mcu_top #(.KC_TICKS(KC_TICKS), .PC_TICKS(PC_TICKS)) dut0 (
		.__clk(clk), .rst_n(rst_n), .start(start), .stop(stop), .cycle(cycle), .irq(irq),
		.mem_ok(mem_ok), .rdt(rdt), .run(run), .halted(halted), .mem_rd(mem_rd),
		.mem_wr(mem_wr), .w_ir(w_ir), .w_ac(w_ac), .w_ar(w_ar), .w_ic(w_ic), .w_r(w_r),
		.shift_step(shift_step), .irq_ack(irq_ack), .reg_sel(reg_sel),
		.state_code(state_code)
	);

	bind mcu_top mcu_asserts asrt0 (
		.__clk(__clk), .rst_n(rst_n), .mem_rd(mem_rd), .mem_wr(mem_wr), .w_ir(w_ir),
		.w_ac(w_ac), .w_ar(w_ar), .w_ic(w_ic), .w_r(w_r), .shift_step(shift_step),
		.irq_ack(irq_ack), .reg_sel(reg_sel)
	);

	always #2 clk = ~clk;

	function automatic op_t dec_op(input logic [15:0] w);
		case (w[15:10])
			OPC_LW:   return OP_LW;
			OPC_RW:   return OP_RW;
			OPC_UJ:   return OP_UJ;
			OPC_SHC:  return OP_SHC;
			OPC_LWRS: return OP_LWRS;
			OPC_HLT:  return OP_HLT;
			default:  return OP_ILL;
		endcase
	endfunction

	// execute length is the shift count (min 1) for SHC and a+1 for LWRS
	function automatic int exec_len(input logic [15:0] w);
		if (dec_op(w) == OP_SHC) begin
			return (w[3:0] == 4'd0) ? 1 : int'(w[3:0]);
		end else if (dec_op(w) == OP_LWRS) begin
			return int'(w[8:6]) + 1;
		end
		return 1;
	endfunction

	// mode 0 gives all opcodes with HLT rare, mode 1 only SHC and LWRS
	// mode 2 no HLT and mode 3 only HLT
	function automatic logic [15:0] gen_word(input int mode);
		logic [5:0] opc;
		int r;
		r = $urandom_range(15, 0);
		if (r < 3) opc = OPC_LW;
		else if (r < 6) opc = OPC_RW;
		else if (r < 8) opc = OPC_UJ;
		else if (r < 11) opc = OPC_SHC;
		else if (r < 14) opc = OPC_LWRS;
		else if (r == 14) opc = 6'h02;
		else opc = (mode == 0) ? OPC_HLT : OPC_LW;
		if (mode == 1) opc = r[0] ? OPC_SHC : OPC_LWRS;
		if (mode == 3) opc = OPC_HLT;
		return {opc, 10'($urandom)};
	endfunction

	task automatic chk(input string sig, input logic [3:0] exp, input logic [3:0] act);
		if (exp !== act) begin
			errs++;
			$display("** Error %s: %s expected %h actual %h", cur_test, sig, exp, act);
		end
	endtask

	task automatic end_test();
		tests_run++;
		if (errs != test_errs) tests_failed++;
		$display("test %s done with %0d errors", cur_test, errs - test_errs);
		test_errs = errs;
	endtask

	task automatic report_timeout(input string what);
		$display("timeout waiting for %s in test %s", what, cur_test);
		tests_run++;
		tests_failed++;
		timed_out = 1'b1;
	endtask

	// memory model and random irq pulses
	always @(posedge clk) begin
		if (!rst_n) begin
			mem_ok <= 1'b0;
			mem_wait = 0;
		end else begin
			mem_ok <= 1'b0;
			if (mem_wait > 0) begin
				mem_wait--;
				if (mem_wait == 0) begin
					mem_ok <= 1'b1;
					rdt <= gen_word(prog_mode);
				end
			end
			if (mem_rd) mem_wait = $urandom_range(4, 1);
			if (irq_rand) irq <= ($urandom_range(29, 0) == 0);
		end
	end

	// cycle model with strobes one cycle after their state
	always @(posedge clk) begin : model
		logic two, bmod, last, hlt_p, irqt_p, stepd_p;
		op_t op;
		state_t nx;
		uop_t u;
		if (!rst_n) begin
			m_state = ST_IDLE;
			m_first = 1'b1;
			{m_start, m_wait, m_cyc} = 3'b000;
			m_ph = 0;
			m_e = 0;
			m_uop = '0;
			m_code = ST_IDLE;
		end else begin
			op = dec_op(m_ir);
			two = (m_ir[2:0] == 3'd0) && !(op inside {OP_SHC, OP_HLT});
			bmod = (m_ir[5:3] != 3'd0) && !(op inside {OP_SHC, OP_HLT});
			last = (m_state == ST_KC && m_ph == KC_TICKS - 1) ||
				(m_state == ST_IRQ && m_ph == 1) || (m_state == ST_PC && m_ph == PC_TICKS - 1);
			u = '0;
			nx = m_state;
			case (m_state)
				ST_IDLE: begin
					if ((m_start && !m_wait) || m_cyc) nx = ST_FETCH;
					else if (m_start && irq) nx = ST_IRQ;
				end
				ST_FETCH: begin
					u.mem_rd = m_first;
					if (mem_ok) begin
						m_ir = rdt;
						nx = ST_DECODE;
					end
				end
				ST_DECODE: begin
					u.w_ir = 1'b1;
					u.reg_sel = m_ir[2:0];
					m_e = 0;
					nx = two ? ST_ARG : (bmod ? ST_BMOD : ST_EXEC);
				end
				ST_ARG: begin
					u.mem_rd = m_first;
					u.w_ac = mem_ok;
					if (mem_ok) nx = bmod ? ST_BMOD : ST_EXEC;
				end
				ST_BMOD: begin
					u.w_ac = 1'b1;
					u.reg_sel = m_ir[5:3];
					nx = ST_EXEC;
				end
				ST_EXEC: begin
					u.reg_sel = (op inside {OP_LW, OP_RW, OP_SHC}) ? m_ir[8:6] : 3'd0;
					u.w_r = (op inside {OP_LW, OP_LWRS});
					u.w_ar = (op == OP_RW);
					u.mem_wr = (op == OP_RW);
					u.w_ic = (op == OP_UJ);
					u.shift_step = (op == OP_SHC) && (m_ir[3:0] != 4'd0);
					if (op == OP_LWRS) u.reg_sel = 3'(m_e);
					if (m_e == exec_len(m_ir) - 1) nx = ST_KC;
					else m_e++;
				end
				ST_KC: if (last) nx = (irq && (m_start || m_cyc)) ? ST_IRQ : ST_PC;
				ST_IRQ: begin
					u.irq_ack = m_first;
					u.w_ic = !m_first;
					if (last) nx = ST_PC;
				end
				ST_PC: if (last) nx = (m_start && !m_wait) ? ST_FETCH : ST_IDLE;
				default: nx = ST_IDLE;
			endcase
			hlt_p = (m_state == ST_EXEC) && (op == OP_HLT);
			irqt_p = (m_state == ST_IRQ) && m_first;
			stepd_p = (m_state == ST_PC) && last;
			if (irqt_p || stepd_p) m_cyc = 1'b0;
			else if (cycle && !m_start) m_cyc = 1'b1;
			if (stop || irqt_p) m_wait = 1'b0;
			else if (hlt_p) m_wait = 1'b1;
			if (stop) m_start = 1'b0;
			else if (start) m_start = 1'b1;
			if (nx == ST_KC && m_state != ST_KC) m_kc_cnt++;
			m_ph = (nx != m_state) ? 0 : m_ph + 1;
			m_first = (nx != m_state);
			m_code = m_state;
			m_state = nx;
			m_uop = u;
		end
	end

	// compare against the model and count strobes per instruction
	always @(negedge clk) begin
		if (checking) begin
			chk("run", {3'b0, m_start && !m_wait}, {3'b0, run});
			chk("halted", {3'b0, m_wait}, {3'b0, halted});
			chk("state_code", m_code, state_code);
			chk("rd,wr,ir,ac", {m_uop.mem_rd, m_uop.mem_wr, m_uop.w_ir, m_uop.w_ac},
				{mem_rd, mem_wr, w_ir, w_ac});
			chk("ar,ic,r,shift", {m_uop.w_ar, m_uop.w_ic, m_uop.w_r, m_uop.shift_step},
				{w_ar, w_ic, w_r, shift_step});
			chk("irq_ack", {3'b0, m_uop.irq_ack}, {3'b0, irq_ack});
			chk("reg_sel", {1'b0, m_uop.reg_sel}, {1'b0, reg_sel});
			if (w_ir) begin
				ir_cnt++;
				if (have_w) begin
					chk("shift pulses", (dec_op(cur_w) == OP_SHC) ? cur_w[3:0] : 4'd0,
						4'(sh_cnt));
					chk("w_r pulses", (dec_op(cur_w) == OP_LWRS) ? 4'(exec_len(cur_w)) :
						{3'b0, dec_op(cur_w) == OP_LW}, 4'(wr_cnt));
				end
				have_w = 1'b1;
				cur_w = m_ir;
				sh_cnt = 0;
				wr_cnt = 0;
			end
			if (shift_step) sh_cnt++;
			if (w_r) begin
				if (dec_op(cur_w) == OP_LWRS) chk("lwrs reg_sel", 4'(wr_cnt), {1'b0, reg_sel});
				wr_cnt++;
			end
		end
	end

	// tests after reset, leaving early on a timeout
	task automatic run_tests();
		int n;
		int base;
		logic [3:0] prev;

		cur_test = "run";
		irq_rand = 1'b1;
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		base = m_kc_cnt;
		for (n = 0; m_kc_cnt < base + 40 && n < 20 * LIMIT; n++) @(negedge clk);
		if (n >= 20 * LIMIT) begin
			report_timeout("40 instructions");
			return;
		end
		end_test();

		cur_test = "shift";
		prog_mode = 1;
		base = m_kc_cnt;
		for (n = 0; m_kc_cnt < base + 30 && n < 20 * LIMIT; n++) @(negedge clk);
		if (n >= 20 * LIMIT) begin
			report_timeout("30 shift and group instructions");
			return;
		end
		end_test();

		// halt then wake up through an interrupt
		cur_test = "halt";
		irq_rand = 1'b0;
		prog_mode = 3;
		@(posedge clk);
		irq <= 1'b0;
		for (n = 0; !halted && n < LIMIT; n++) @(negedge clk);
		if (n >= LIMIT) begin
			report_timeout("halted");
			return;
		end
		prog_mode = 2;
		for (n = 0; state_code != ST_IDLE && n < LIMIT; n++) @(negedge clk);
		if (n >= LIMIT) begin
			report_timeout("idle after halt");
			return;
		end
		if (run) begin
			errs++;
			$display("** Error halt: run expected 0 actual 1");
		end
		@(posedge clk);
		irq <= 1'b1;
		for (n = 0; !irq_ack && n < LIMIT; n++) @(negedge clk);
		if (n >= LIMIT) begin
			report_timeout("irq_ack");
			return;
		end
		@(posedge clk);
		irq <= 1'b0;
		for (n = 0; (halted || !mem_rd) && n < LIMIT; n++) @(negedge clk);
		if (n >= LIMIT) begin
			report_timeout("fetch after interrupt");
			return;
		end
		end_test();

		cur_test = "step";
		repeat ($urandom_range(40, 5)) @(posedge clk);
		stop <= 1'b1;
		@(posedge clk);
		stop <= 1'b0;
		for (n = 0; state_code != ST_IDLE && n < LIMIT; n++) @(negedge clk);
		if (n >= LIMIT) begin
			report_timeout("idle after stop");
			return;
		end
		@(posedge clk);
		base = ir_cnt;
		cycle <= 1'b1;
		@(posedge clk);
		cycle <= 1'b0;
		for (n = 0; state_code == ST_IDLE && n < LIMIT; n++) @(negedge clk);
		if (n >= LIMIT) begin
			report_timeout("leaving idle");
			return;
		end
		for (n = 0; state_code != ST_IDLE && n < LIMIT; n++) @(negedge clk);
		if (n >= LIMIT) begin
			report_timeout("idle after step");
			return;
		end
		@(posedge clk);
		if (ir_cnt - base != 1) begin
			errs++;
			$display("** Error step: instructions expected 1 actual %0d", ir_cnt - base);
		end
		end_test();

		cur_test = "irq";
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		repeat ($urandom_range(30, 10)) @(posedge clk);
		irq <= 1'b1;
		prev = state_code;
		for (n = 0; !irq_ack && n < LIMIT; n++) begin
			prev = state_code;
			@(negedge clk);
		end
		if (n >= LIMIT) begin
			report_timeout("irq_ack at cycle end");
			return;
		end
		if (prev != ST_KC) begin
			errs++;
			$display("** Error irq: state before IRQ expected %h actual %h", ST_KC, prev);
		end
		@(posedge clk);
		irq <= 1'b0;
		@(negedge clk);
		if (!w_ic) begin
			errs++;
			$display("** Error irq: w_ic expected 1 actual 0");
		end
		end_test();
	endtask

	initial begin
		void'($urandom(32'hc8b902bf));
		{rst_n, start, stop, cycle, irq, mem_ok} <= 6'b0;
		rdt <= 16'h0;
		{checking, irq_rand, have_w, timed_out} = 4'b0;
		prog_mode = 0;
		cur_test = "reset";
		@(posedge clk);
		checking = 1'b1;
		repeat (7) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		if ({run, halted, mem_rd, mem_wr, w_ir, w_ac, w_ar, w_ic, w_r, shift_step, irq_ack,
			reg_sel, state_code} != '0) begin
			errs++;
			$display("** Error reset: outputs expected 0 actual %b", {run, halted, mem_rd,
				mem_wr, w_ir, w_ac, w_ar, w_ic, w_r, shift_step, irq_ack, reg_sel, state_code});
		end
		end_test();

		run_tests();

		$display("tests run %0d, tests with errors %0d, errors %0d", tests_run, tests_failed, errs);
		if (errs == 0 && !timed_out) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* build.f */
isa_pkg.sv
mcu_pkg.sv
mcu_if.sv
mcu_panel.sv
mcu_sequencer.sv
mcu_counters.sv
mcu_microops.sv
mcu_top.sv
mcu_asserts.sv
tb_mcu.sv

/* Makefile */
# Verilator flow for the microinstruction control unit

LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module tb_mcu -f build.f

sim:
	verilator --binary --timing --assert --top-module tb_mcu -f build.f -o sim_mcu
	./obj_dir/sim_mcu > $(LOG) 2>&1 || true
	cat $(LOG)
	! grep -q "Test failed" $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
